// File: accessConfig.sv
//==============================
// config registers for the address generator
// base address, bucket bursts, header bursts, written by strobe
//==============================

module accessConfig
	import oramPkg::*, dramPkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic cfgWrite,
	input logic [1:0] cfgSel,
	input logic [31:0] cfgData,
	input logic pathBusy,
	output dramAddrT baseAddr,
	output burstCountT bucketBursts,
	output burstCountT headerBursts
);

	// register select codes
	localparam logic [1:0] SelBase = 2'd0;
	localparam logic [1:0] SelBucket = 2'd1;
	localparam logic [1:0] SelHeader = 2'd2;

	// a bucket always has at least one burst
	function automatic burstCountT clampBursts(input logic [31:0] value);
		burstCountT low;
		low = value[7:0];
		return (low == '0) ? burstCountT'(1) : low;
	endfunction

	logic writeOk;

	// locked for the whole path walk
	assign writeOk = cfgWrite && !pathBusy;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			baseAddr <= '0;
			bucketBursts <= burstCountT'(4);
			headerBursts <= burstCountT'(1);
		end else if (writeOk) begin
			case (cfgSel)
				SelBase: baseAddr <= dramAddrT'(cfgData);
				SelBucket: bucketBursts <= clampBursts(cfgData);
				SelHeader: headerBursts <= clampBursts(cfgData);
				// select 3 is unmapped
				default: ;
			endcase
		end
	end

endmodule

// File: bucketAddrGen.sv
//==============================
// forms one DRAM command per burst for every bucket on a path
// pops a request when idle and pushes into the command FIFO
//==============================

module bucketAddrGen
	import oramPkg::*, dramPkg::*;
#(
	parameter int treeDepth = 6
) (
	input logic Clock,
	input logic rstN,
	input logic reqEmpty,
	input accessReq reqHead,
	output logic reqPop,
	input dramAddrT baseAddr,
	input burstCountT bucketBursts,
	input burstCountT headerBursts,
	input logic cmdFull,
	output logic cmdPush,
	output dramCmd cmdIn,
	output logic pathBusy
);

	// ==============================
	// walk state
	// ==============================

	logic active;
	// latched from the popped request
	dramOpT walkOp;
	logic walkHeader;
	burstCountT burstCnt;

	// from the level walker
	bucketIdxT bucketIdx;
	logic lastLevel;

	burstCountT burstsPerBucket;
	logic bucketDone;
	logic advance;

	// take a new request only between walks
	assign reqPop = !active && !reqEmpty;

	assign burstsPerBucket = walkHeader ? headerBursts : bucketBursts;
	assign bucketDone = (burstCnt == burstsPerBucket - 1'b1);

	// stall in place while the command FIFO is full
	assign cmdPush = active && !cmdFull;
	assign advance = cmdPush && bucketDone && !lastLevel;

	assign pathBusy = active;

	pathBucketIndex #(
		.treeDepth(treeDepth)
	) levelWalk (
		.Clock(Clock),
		.rstN(rstN),
		.restart(reqPop),
		.leaf(reqHead.leaf),
		.advance(advance),
		.level(),
		.bucketIdx(bucketIdx),
		.lastLevel(lastLevel)
	);

	// ==============================
	// address
	// ==============================

	dramAddrT burstOffset;

	// stride is always the full bucket, even in header mode
	assign burstOffset = dramAddrT'(bucketIdx) * dramAddrT'(bucketBursts)
		+ dramAddrT'(burstCnt);

	assign cmdIn.op = walkOp;
	assign cmdIn.addr = baseAddr + burstOffset * dramAddrT'(BurstBytes);

	// op and mode held for the whole walk
	always_ff @(posedge Clock) begin
		if (reqPop) begin
			walkOp <= reqHead.isRead ? dramRead : dramWrite;
			walkHeader <= reqHead.headerOnly;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			burstCnt <= '0;
		end else if (reqPop) begin
			active <= 1'b1;
			burstCnt <= '0;
		end else if (cmdPush) begin
			if (bucketDone) begin
				burstCnt <= '0;
				// last burst of the leaf bucket ends the walk
				if (lastLevel) begin
					active <= 1'b0;
				end
			end else begin
				burstCnt <= burstCnt + 1'b1;
			end
		end
	end

endmodule

// File: dramPkg.sv
//==============================
// DRAM command stream types shared by the address generator and the top
//==============================

package dramPkg;

	// ==============================
	// address space
	// ==============================

	localparam int DramAddrWidth = 32;

	typedef logic [DramAddrWidth-1:0] dramAddrT;

	// address units covered by one burst
	localparam int BurstBytes = 64;

	// ==============================
	// commands
	// ==============================

	// single bit opcode, matches the request isRead bit
	typedef enum logic {
		dramWrite = 1'b0,
		dramRead = 1'b1
	} dramOpT;

	// one command per burst
	typedef struct packed {
		dramOpT op;
		dramAddrT addr;
	} dramCmd;

endpackage

// File: oramPkg.sv
//==============================
// tree geometry and access request types for the path ORAM front end
// imported by the address generator, the config block and the top level
//==============================

package oramPkg;

	// ==============================
	// tree geometry
	// ==============================

	// widest leaf label supported by the datapath
	localparam int LeafWidthMax = 16;

	// leaf label, only the low treeDepth bits are used
	typedef logic [LeafWidthMax-1:0] leafT;

	// level number, root is level 0
	typedef logic [4:0] levelT;

	// heap order bucket index, one bit wider than a leaf
	typedef logic [LeafWidthMax:0] bucketIdxT;

	// bursts per bucket or per header
	typedef logic [7:0] burstCountT;

	// ==============================
	// requester side
	// ==============================

	// one path access as posted by the backend
	typedef struct packed {
		// 1 for read, 0 for write
		logic isRead;
		// only the bucket headers are touched
		logic headerOnly;
		leafT leaf;
	} accessReq;

endpackage

// File: pathAccessTb.sv
//==============================
// directed testbench for the path address front end
// models the DRAM as a sink and checks every command in order
//==============================

module pathAccessTb
	import oramPkg::*, dramPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TreeDepth = 6;
	// worst case commands per test: 28, 7, 28, 20x28, 6x28, 14
	localparam int TotalCmds = 28 + 7 + 28 + 560 + 168 + 14;
	localparam int TimeoutCycles = 2 * TotalCmds + 2000;

	logic Clock = 1'b0;
	logic rstN;
	logic reqWrite;
	accessReq reqData;
	logic reqFull;
	logic cfgWrite;
	logic [1:0] cfgSel;
	logic [31:0] cfgData;
	logic cmdValid;
	logic cmdReady = 1'b1;
	dramCmd cmd;
	logic pathBusy;

	// reference copy of the config registers
	dramAddrT modelBase;
	burstCountT modelBucket;
	burstCountT modelHeader;

	// commands still owed by the DUT, oldest first
	dramCmd expQ[$];
	dramCmd expCmd;
	int gotCount = 0;
	int cycleCount = 0;
	logic randomReady = 1'b0;
	logic [31:0] stimState = 32'h37ed_c758;
	logic [31:0] readyState = 32'h37ed_c758;

	pathAccessTop #(
		.treeDepth(TreeDepth),
		.reqDepth(4),
		.cmdDepth(8)
	) dut (
		.Clock(Clock),
		.rstN(rstN),
		.reqWrite(reqWrite),
		.reqData(reqData),
		.reqFull(reqFull),
		.cfgWrite(cfgWrite),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmd(cmd),
		.pathBusy(pathBusy)
	);

	always #10 Clock = !Clock;

	// ==============================
	// helpers
	// ==============================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic failRun(input string why);
		$display("Testbench failed");
		$fatal(1, "%s", why);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
			failRun("value mismatch");
		end
	endtask

	// inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge Clock);
		#2;
	endtask

	// expected commands for one access, root to leaf
	task automatic expectAccess(input accessReq r);
		int k;
		int b;
		logic [31:0] idx;
		burstCountT n;
		dramCmd c;
		n = r.headerOnly ? modelHeader : modelBucket;
		for (k = 0; k <= TreeDepth; k++) begin
			idx = (32'd1 << k) - 32'd1 + (32'(r.leaf) >> (TreeDepth - k));
			for (b = 0; b < int'(n); b++) begin
				c.op = r.isRead ? dramRead : dramWrite;
				// stride is the full bucket even for headers
				c.addr = modelBase + (idx * 32'(modelBucket) + 32'(b)) * 32'(BurstBytes);
				expQ.push_back(c);
			end
		end
	endtask

	// a write against a full FIFO is lost, so the model skips it too
	task automatic postRequest(input logic isRead, input logic headerOnly, input leafT leaf);
		reqData.isRead = isRead;
		reqData.headerOnly = headerOnly;
		reqData.leaf = leaf;
		reqWrite = 1'b1;
		if (!reqFull) begin
			expectAccess(reqData);
		end
		tick();
		reqWrite = 1'b0;
	endtask

	task automatic writeConfig(input logic [1:0] sel, input logic [31:0] data);
		cfgSel = sel;
		cfgData = data;
		cfgWrite = 1'b1;
		// registers locked during a walk
		if (!pathBusy) begin
			case (sel)
				2'd0: modelBase = data;
				2'd1: modelBucket = (data[7:0] == 8'd0) ? 8'd1 : data[7:0];
				2'd2: modelHeader = (data[7:0] == 8'd0) ? 8'd1 : data[7:0];
				default: ;
			endcase
		end
		tick();
		cfgWrite = 1'b0;
	endtask

	// drain the owed commands, then the DUT must be idle
	task automatic waitIdle();
		while (expQ.size() != 0) begin
			tick();
		end
		checkValue("pathBusy", 32'(pathBusy), 32'd0);
		checkValue("cmdValid", 32'(cmdValid), 32'd0);
	endtask

	// ==============================
	// DRAM sink and watchdog
	// ==============================

	// mid cycle, values are those seen by the next edge
	always @(negedge Clock) begin
		if (rstN && cmdValid && cmdReady) begin
			if (expQ.size() == 0) begin
				failRun("DUT sent a command that no access asked for");
			end else begin
				expCmd = expQ.pop_front();
				checkValue("cmd.op", 32'(cmd.op), 32'(expCmd.op));
				checkValue("cmd.addr", cmd.addr, expCmd.addr);
				gotCount++;
			end
		end
	end

	always @(posedge Clock) begin
		#2;
		if (randomReady) begin
			readyState = xorshift32(readyState);
			cmdReady = readyState[0];
		end else begin
			cmdReady = 1'b1;
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > TimeoutCycles) begin
			$display("Testbench failed");
			$fatal(1, "timeout, the DUT stopped producing the expected commands");
		end
	end

	// ==============================
	// tests
	// ==============================

	task automatic testResetAndRead();
		int start;
		checkValue("cmdValid", 32'(cmdValid), 32'd0);
		checkValue("pathBusy", 32'(pathBusy), 32'd0);
		checkValue("reqFull", 32'(reqFull), 32'd0);
		start = gotCount;
		postRequest(1'b1, 1'b0, leafT'(0));
		waitIdle();
		checkValue("command count", 32'(gotCount - start), 32'd28);
	endtask

	task automatic testHeaderWrite();
		int start;
		start = gotCount;
		stimState = xorshift32(stimState);
		postRequest(1'b0, 1'b1, leafT'(stimState[5:0]));
		waitIdle();
		// one burst per bucket
		checkValue("command count", 32'(gotCount - start), 32'd7);
	endtask

	task automatic testConfigChange();
		writeConfig(2'd0, 32'h0010_0000);
		writeConfig(2'd1, 32'd2);
		postRequest(1'b1, 1'b0, leafT'(6'h2b));
		while (!pathBusy) begin
			tick();
		end
		// lands mid walk, model and DUT both ignore it
		writeConfig(2'd0, 32'hdead_0000);
		waitIdle();
		postRequest(1'b0, 1'b0, leafT'(6'h14));
		waitIdle();
		writeConfig(2'd1, 32'd4);
	endtask

	task automatic testBackPressure();
		int i;
		randomReady = 1'b1;
		for (i = 0; i < 20; i++) begin
			while (reqFull) begin
				tick();
			end
			stimState = xorshift32(stimState);
			postRequest(stimState[6], stimState[7], leafT'(stimState[5:0]));
		end
		waitIdle();
		randomReady = 1'b0;
	endtask

	task automatic testFifoFull();
		int i;
		for (i = 0; i < 6 && !reqFull; i++) begin
			postRequest(1'b1, 1'b0, leafT'(i * 9));
		end
		if (!reqFull) begin
			failRun("request FIFO never reported full");
		end
		// both dropped by the FIFO and by the model
		postRequest(1'b0, 1'b0, leafT'(6'h3f));
		postRequest(1'b0, 1'b1, leafT'(6'h21));
		waitIdle();
	endtask

	task automatic testZeroBursts();
		writeConfig(2'd1, 32'd0);
		writeConfig(2'd2, 32'h0000_0100);
		postRequest(1'b1, 1'b0, leafT'(6'h3c));
		postRequest(1'b0, 1'b1, leafT'(6'h05));
		waitIdle();
	endtask

	initial begin
		rstN = 1'b0;
		reqWrite = 1'b0;
		reqData = '0;
		cfgWrite = 1'b0;
		cfgSel = 2'd0;
		cfgData = 32'd0;
		modelBase = 32'd0;
		modelBucket = 8'd4;
		modelHeader = 8'd1;
		repeat (10) @(posedge Clock);
		#2;
		rstN = 1'b1;
		tick();
		testResetAndRead();
		testHeaderWrite();
		testConfigChange();
		testBackPressure();
		testFifoFull();
		testZeroBursts();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: pathAccessTop.sv
//==============================
// path address front end top level
// request FIFO, config block, address generator, command FIFO
//==============================

module pathAccessTop
	import oramPkg::*, dramPkg::*;
#(
	parameter int treeDepth = 6,
	parameter int reqDepth = 4,
	parameter int cmdDepth = 8
) (
	input logic Clock,
	input logic rstN,
	input logic reqWrite,
	input accessReq reqData,
	output logic reqFull,
	input logic cfgWrite,
	input logic [1:0] cfgSel,
	input logic [31:0] cfgData,
	output logic cmdValid,
	input logic cmdReady,
	output dramCmd cmd,
	output logic pathBusy
);

	// request side
	logic reqEmpty;
	logic reqPop;
	accessReq reqHead;

	// config levels
	dramAddrT baseAddr;
	burstCountT bucketBursts;
	burstCountT headerBursts;

	// command side
	logic cmdFull;
	logic cmdPush;
	logic cmdEmpty;
	dramCmd cmdIn;

	assign cmdValid = !cmdEmpty;

	// ==============================
	// request queue
	// ==============================

	syncFifo #(
		.payloadT(accessReq),
		.depth(reqDepth)
	) reqFifo (
		.Clock(Clock),
		.rstN(rstN),
		.push(reqWrite),
		.pushData(reqData),
		.full(reqFull),
		.pop(reqPop),
		.popData(reqHead),
		.empty(reqEmpty)
	);

	accessConfig cfgRegs (
		.Clock(Clock),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.pathBusy(pathBusy),
		.baseAddr(baseAddr),
		.bucketBursts(bucketBursts),
		.headerBursts(headerBursts)
	);

	bucketAddrGen #(
		.treeDepth(treeDepth)
	) addrGen (
		.Clock(Clock),
		.rstN(rstN),
		.reqEmpty(reqEmpty),
		.reqHead(reqHead),
		.reqPop(reqPop),
		.baseAddr(baseAddr),
		.bucketBursts(bucketBursts),
		.headerBursts(headerBursts),
		.cmdFull(cmdFull),
		.cmdPush(cmdPush),
		.cmdIn(cmdIn),
		.pathBusy(pathBusy)
	);

	// ==============================
	// command queue to DRAM
	// ==============================

	// transfer on cmdValid and cmdReady
	syncFifo #(
		.payloadT(dramCmd),
		.depth(cmdDepth)
	) cmdFifo (
		.Clock(Clock),
		.rstN(rstN),
		.push(cmdPush),
		.pushData(cmdIn),
		.full(cmdFull),
		.pop(cmdValid && cmdReady),
		.popData(cmd),
		.empty(cmdEmpty)
	);

endmodule

// File: pathBucketIndex.sv
//==============================
// walks a tree path from the root to the leaf in heap order
// restart latches the leaf, each advance descends one level
//==============================

module pathBucketIndex
	import oramPkg::*;
#(
	parameter int treeDepth = 6
) (
	input logic Clock,
	input logic rstN,
	input logic restart,
	input leafT leaf,
	input logic advance,
	output levelT level,
	output bucketIdxT bucketIdx,
	output logic lastLevel
);

	// remaining path bits, next one always at treeDepth-1
	leafT pathBits;
	logic nextBit;

	assign nextBit = pathBits[treeDepth-1];

	assign lastLevel = (level == levelT'(treeDepth));

	// path bits shift out msb first, no reset needed
	always_ff @(posedge Clock) begin
		if (restart) begin
			pathBits <= leaf;
		end else if (advance) begin
			pathBits <= pathBits << 1;
		end
	end

	// ==============================
	// level and heap index
	// ==============================

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			level <= '0;
			bucketIdx <= '0;
		end else if (restart) begin
			// root is index 0
			level <= '0;
			bucketIdx <= '0;
		end else if (advance && !lastLevel) begin
			level <= level + 1'b1;
			// left child 2i+1, right child 2i+2
			bucketIdx <= (bucketIdx << 1) + bucketIdxT'(1) + bucketIdxT'(nextBit);
		end
	end

endmodule

// File: project.f
oramPkg.sv
dramPkg.sv
syncFifo.sv
accessConfig.sv
pathBucketIndex.sv
bucketAddrGen.sv
pathAccessTop.sv
pathAccessTb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
# exit status is nonzero when the simulation fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f project.f \
	--top-module pathAccessTb \
	-o pathAccessSim

./obj_dir/pathAccessSim

// File: syncFifo.sv
//==============================
// synchronous FIFO with a type parameter for its payload
// push data shows up at the head one cycle later
//==============================

module syncFifo #(
	parameter type payloadT = logic [7:0],
	parameter int depth = 4
) (
	input logic Clock,
	input logic rstN,
	input logic push,
	input payloadT pushData,
	output logic full,
	input logic pop,
	output payloadT popData,
	output logic empty
);

	localparam int PtrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int CountWidth = $clog2(depth + 1);

	// storage, no reset needed
	payloadT mem [depth];

	logic [PtrWidth-1:0] readPtr;
	logic [PtrWidth-1:0] writePtr;
	logic [CountWidth-1:0] count;

	logic doPush;
	logic doPop;

	assign full = (count == CountWidth'(depth));
	assign empty = (count == '0);

	// push while full only with a pop in the same cycle
	assign doPop = pop && !empty;
	assign doPush = push && (!full || doPop);

	assign popData = mem[readPtr];

	always_ff @(posedge Clock) begin
		if (doPush) begin
			mem[writePtr] <= pushData;
		end
	end

	// pointers and occupancy
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				// wrap at depth, which need not be a power of two
				writePtr <= (writePtr == PtrWidth'(depth - 1)) ? '0 : writePtr + 1'b1;
			end
			if (doPop) begin
				readPtr <= (readPtr == PtrWidth'(depth - 1)) ? '0 : readPtr + 1'b1;
			end
			if (doPush && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !doPush) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule
